// File: i3c_bus_pkg.sv
// Pin sampling constants for the I3C bus monitor
// SYNC_STAGES must be at least 2 and STABLE_CYCLES at least 2
// The testbench sizes its pin hold times from these values
`default_nettype none

package i3c_bus_pkg;

  // Flip-flops in each pin synchronizer
  localparam int unsigned SYNC_STAGES = 2;

  // Equal consecutive samples before a pin level is accepted
  localparam int unsigned STABLE_CYCLES = 4;

  // Width of the stability counter, counts 0 .. STABLE_CYCLES-1
  localparam int unsigned STABLE_CNT_W = $clog2(STABLE_CYCLES);

  // Cycles from a pin change to the filtered level and its pulses
  localparam int unsigned SAMPLE_LATENCY = SYNC_STAGES + STABLE_CYCLES;

endpackage

`default_nettype wire

// File: i3c_event_pkg.sv
// Event codes and pattern lengths for the I3C bus monitor
// Codes are reported to the host over the req/ack handshake
`default_nettype none

package i3c_event_pkg;

  localparam int unsigned EVENT_W = 2;

  typedef enum logic [EVENT_W-1:0] {
    EV_NONE         = 2'd0,
    EV_HDR_EXIT     = 2'd1,
    EV_TARGET_RESET = 2'd2
  } event_code_t;

  // SDA falling edges with SCL low in the HDR exit pattern
  localparam int unsigned HDR_EXIT_EDGES = 4;

  // Minimum SDA falling edges with SCL low in the Target Reset pattern
  localparam int unsigned TRST_EDGES = 7;
  localparam int unsigned TRST_CNT_W = $clog2(TRST_EDGES + 1);

endpackage

`default_nettype wire

// File: i3c_bus_sampler.sv
// Synchronizes and filters raw SCL/SDA and derives bus conditions
// Outputs lag the pins by SYNC_STAGES + STABLE_CYCLES cycles
// Pin pulses shorter than STABLE_CYCLES are dropped; idle bus reads high
`timescale 1ns/1ps
`default_nettype none

module i3c_bus_sampler
  import i3c_bus_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_high_o,
  output logic scl_low_o,
  output logic sda_high_o,
  output logic sda_low_o,
  output logic scl_pos_o,
  output logic scl_neg_o,
  output logic sda_pos_o,
  output logic sda_neg_o,
  output logic start_det_o,
  output logic rstart_det_o,
  output logic stop_det_o
);

  // Index 0 is SCL, index 1 is SDA
  logic [1:0]              pin_raw;
  logic [1:0]              pin_sync;
  logic [SYNC_STAGES-1:0]  sync_q [2];
  logic [STABLE_CNT_W-1:0] stable_cnt_q [2];
  logic [1:0]              level_q;
  logic [1:0]              rise_q;
  logic [1:0]              fall_q;
  logic                    start_cond;
  logic                    in_xfer_q;

  assign pin_raw = {sda_i, scl_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 2; i++) begin
        sync_q[i] <= '1;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        sync_q[i] <= {sync_q[i][SYNC_STAGES-2:0], pin_raw[i]};
      end
    end
  end

  assign pin_sync = {sync_q[1][SYNC_STAGES-1], sync_q[0][SYNC_STAGES-1]};

  // A new level is taken once the synchronized pin has differed
  // from the current level for STABLE_CYCLES samples in a row
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      level_q <= 2'b11;
      rise_q  <= 2'b00;
      fall_q  <= 2'b00;
      for (int i = 0; i < 2; i++) begin
        stable_cnt_q[i] <= '0;
      end
    end else begin
      rise_q <= 2'b00;
      fall_q <= 2'b00;
      for (int i = 0; i < 2; i++) begin
        if (pin_sync[i] == level_q[i]) begin
          stable_cnt_q[i] <= '0;
        end else if (stable_cnt_q[i] == STABLE_CNT_W'(STABLE_CYCLES - 1)) begin
          stable_cnt_q[i] <= '0;
          level_q[i]      <= pin_sync[i];
          rise_q[i]       <= pin_sync[i];
          fall_q[i]       <= !pin_sync[i];
        end else begin
          stable_cnt_q[i] <= stable_cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // SDA edges with SCL high are bus conditions
  assign start_cond = fall_q[1] & level_q[0];
  assign stop_det_o = rise_q[1] & level_q[0];

  // Tracks an open transfer so a second START is reported as Sr
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_xfer_q <= 1'b0;
    end else if (stop_det_o) begin
      in_xfer_q <= 1'b0;
    end else if (start_cond) begin
      in_xfer_q <= 1'b1;
    end
  end

  assign start_det_o  = start_cond & !in_xfer_q;
  assign rstart_det_o = start_cond & in_xfer_q;

  assign scl_high_o = level_q[0];
  assign scl_low_o  = !level_q[0];
  assign sda_high_o = level_q[1];
  assign sda_low_o  = !level_q[1];
  assign scl_pos_o  = rise_q[0];
  assign scl_neg_o  = fall_q[0];
  assign sda_pos_o  = rise_q[1];
  assign sda_neg_o  = fall_q[1];

endmodule

`default_nettype wire

// File: target_reset_detector.sv
// Detects the Target Reset pattern: TRST_EDGES or more SDA falls with
// SCL low, then Sr, then P. Only a repeated START arms the detector,
// so the pattern must sit inside an open transfer
`timescale 1ns/1ps
`default_nettype none

module target_reset_detector
  import i3c_event_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic enable_i,
  input  logic scl_low_i,
  input  logic sda_neg_i,
  input  logic rstart_det_i,
  input  logic stop_det_i,
  output logic target_reset_detect_o
);

  logic [TRST_CNT_W-1:0] edge_cnt_q;
  logic                  armed_q;
  logic                  scl_low_q;
  logic                  scl_fall;
  logic                  cnt_full;

  // SCL falling marks the end of a high phase
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_low_q <= 1'b0;
    end else begin
      scl_low_q <= scl_low_i;
    end
  end

  assign scl_fall = scl_low_i & !scl_low_q;
  assign cnt_full = (edge_cnt_q == TRST_CNT_W'(TRST_EDGES));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      edge_cnt_q <= '0;
      armed_q    <= 1'b0;
    end else if (!enable_i || stop_det_i) begin
      edge_cnt_q <= '0;
      armed_q    <= 1'b0;
    end else if (rstart_det_i) begin
      // Sr arms only after enough edges, otherwise starts over
      edge_cnt_q <= '0;
      armed_q    <= cnt_full;
    end else if (scl_fall) begin
      // SCL went high and low again without Sr, or Sr without P
      edge_cnt_q <= '0;
      armed_q    <= 1'b0;
    end else if (sda_neg_i && scl_low_i && !cnt_full) begin
      edge_cnt_q <= edge_cnt_q + 1'b1;
    end
  end

  // Same cycle as the STOP
  assign target_reset_detect_o = enable_i & armed_q & stop_det_i;

endmodule

`default_nettype wire

// File: i3c_bus_monitor.sv
// Pattern detection on the filtered bus: HDR exit and Target Reset
// HDR mode is supplied by the host; no HDR entry logic here
// Detect outputs are single-cycle pulses in the cycle of the STOP
`timescale 1ns/1ps
`default_nettype none

module i3c_bus_monitor
  import i3c_event_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic enable_i,
  input  logic hdr_mode_i,
  input  logic scl_low_i,
  input  logic sda_high_i,
  input  logic sda_neg_i,
  input  logic rstart_det_i,
  input  logic stop_det_i,
  output logic hdr_exit_detect_o,
  output logic target_reset_detect_o
);

  // One-hot edge counter, the set bit walks down one place per SDA fall
  logic [HDR_EXIT_EDGES:0] hdr_edge_q;
  logic                    hdr_armed_q;
  logic                    hdr_arm;

  assign hdr_arm = hdr_mode_i & scl_low_i & sda_high_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hdr_edge_q  <= {1'b1, {HDR_EXIT_EDGES{1'b0}}};
      hdr_armed_q <= 1'b0;
    end else if (!enable_i || stop_det_i) begin
      hdr_edge_q  <= {1'b1, {HDR_EXIT_EDGES{1'b0}}};
      hdr_armed_q <= 1'b0;
    end else if (hdr_arm) begin
      hdr_armed_q <= 1'b1;
    end else if (hdr_armed_q && sda_neg_i && scl_low_i) begin
      // Runs out to all zeros after too many edges
      hdr_edge_q <= {1'b0, hdr_edge_q[HDR_EXIT_EDGES:1]};
    end
  end

  assign hdr_exit_detect_o = enable_i & hdr_edge_q[0] & stop_det_i;

  target_reset_detector u_trst_det (
    .clk_i,
    .rst_ni,
    .enable_i,
    .scl_low_i,
    .sda_neg_i,
    .rstart_det_i,
    .stop_det_i,
    .target_reset_detect_o
  );

endmodule

`default_nettype wire

// File: i3c_event_reporter.sv
// Reports detected events to the host over a four-phase req/ack
// One pending flag per event kind; repeats while pending are merged
// HDR exit goes first when both kinds are pending
`timescale 1ns/1ps
`default_nettype none

module i3c_event_reporter
  import i3c_event_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        hdr_exit_det_i,
  input  logic        target_reset_det_i,
  input  logic        event_ack_i,
  output logic        event_req_o,
  output event_code_t event_code_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_ACK_LOW
  } rep_state_e;

  rep_state_e  state_q;
  event_code_t code_q;
  logic        hdr_pend_q;
  logic        trst_pend_q;
  logic        hdr_avail;
  logic        trst_avail;
  logic        ack_taken;

  // A detect pulse counts as pending in its own cycle
  assign hdr_avail  = hdr_pend_q | hdr_exit_det_i;
  assign trst_avail = trst_pend_q | target_reset_det_i;
  assign ack_taken  = (state_q == ST_REQ) & event_ack_i;

  // A new detect in the ack cycle wins and is reported again
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hdr_pend_q  <= 1'b0;
      trst_pend_q <= 1'b0;
    end else begin
      hdr_pend_q  <= hdr_exit_det_i |
                     (hdr_pend_q & !(ack_taken && code_q == EV_HDR_EXIT));
      trst_pend_q <= target_reset_det_i |
                     (trst_pend_q & !(ack_taken && code_q == EV_TARGET_RESET));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      code_q  <= EV_NONE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (hdr_avail) begin
            code_q  <= EV_HDR_EXIT;
            state_q <= ST_REQ;
          end else if (trst_avail) begin
            code_q  <= EV_TARGET_RESET;
            state_q <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (event_ack_i) begin
            state_q <= ST_ACK_LOW;
          end
        end
        ST_ACK_LOW: begin
          // Host must drop ack before the next request
          if (!event_ack_i) begin
            code_q  <= EV_NONE;
            state_q <= ST_IDLE;
          end
        end
        default: begin
          code_q  <= EV_NONE;
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  assign event_req_o  = (state_q == ST_REQ);
  assign event_code_o = code_q;

endmodule

`default_nettype wire

// File: i3c_monitor_top.sv
// Passive I3C bus monitor: sampler, pattern monitor and event reporter
// Never drives the bus; event_code_o is valid while event_req_o is high
`timescale 1ns/1ps
`default_nettype none

module i3c_monitor_top
  import i3c_event_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        scl_i,
  input  logic        sda_i,
  input  logic        enable_i,
  input  logic        hdr_mode_i,
  input  logic        event_ack_i,
  output logic        event_req_o,
  output event_code_t event_code_o
);

  logic scl_low;
  logic sda_high;
  logic sda_neg;
  logic rstart_det;
  logic stop_det;
  logic hdr_exit_det;
  logic target_reset_det;

  // Levels and pulses the pattern monitor does not need stay open
  i3c_bus_sampler u_sampler (
    .clk_i,
    .rst_ni,
    .scl_i,
    .sda_i,
    .scl_high_o   (),
    .scl_low_o    (scl_low),
    .sda_high_o   (sda_high),
    .sda_low_o    (),
    .scl_pos_o    (),
    .scl_neg_o    (),
    .sda_pos_o    (),
    .sda_neg_o    (sda_neg),
    .start_det_o  (),
    .rstart_det_o (rstart_det),
    .stop_det_o   (stop_det)
  );

  i3c_bus_monitor u_monitor (
    .clk_i,
    .rst_ni,
    .enable_i,
    .hdr_mode_i,
    .scl_low_i             (scl_low),
    .sda_high_i            (sda_high),
    .sda_neg_i             (sda_neg),
    .rstart_det_i          (rstart_det),
    .stop_det_i            (stop_det),
    .hdr_exit_detect_o     (hdr_exit_det),
    .target_reset_detect_o (target_reset_det)
  );

  i3c_event_reporter u_reporter (
    .clk_i,
    .rst_ni,
    .hdr_exit_det_i     (hdr_exit_det),
    .target_reset_det_i (target_reset_det),
    .event_ack_i,
    .event_req_o,
    .event_code_o
  );

endmodule

`default_nettype wire

// File: i3c_monitor_assert.sv
// Handshake and reset checks on the event reporter, attached with bind
// Each request needs a full four-phase cycle before the next one
`timescale 1ns/1ps
`default_nettype none

module i3c_monitor_assert
  import i3c_event_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input logic        event_ack_i,
  input logic        event_req_o,
  input event_code_t event_code_o
);

  // Request drops only in answer to ack
  req_drop_after_ack: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $fell(event_req_o) |-> $past(event_ack_i)
  ) else $error("event_req_o dropped before event_ack_i was raised");

  // New request only once the host has released ack
  req_rise_ack_low: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(event_req_o) |-> !$past(event_ack_i)
  ) else $error("event_req_o rose while event_ack_i was still high");

  // Code held for the whole request, up to the cycle req drops
  code_stable_in_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $past(event_req_o) |-> $stable(event_code_o)
  ) else $error("event_code_o changed while a request was pending");

  reset_state: assert property (
    @(posedge clk_i)
    !rst_ni |-> (!event_req_o && event_code_o == EV_NONE)
  ) else $error("reporter outputs not idle during reset");

endmodule

bind i3c_event_reporter i3c_monitor_assert u_monitor_assert (
  .clk_i,
  .rst_ni,
  .event_ack_i,
  .event_req_o,
  .event_code_o
);

`default_nettype wire

// File: tb_i3c_monitor.sv
// Testbench for the I3C bus monitor, random bus patterns from a fixed-seed LCG
// Pins and ack change on the falling clock edge; one scenario drains before the next
// The burst scenario holds ack high so that both event kinds pile up as pending
`timescale 1ns/1ps
`default_nettype none

module tb_i3c_monitor
  import i3c_bus_pkg::*;
  import i3c_event_pkg::*;
();

  localparam int CLK_HALF        = 20;
  localparam int NUM_SCEN        = 40;
  localparam int MAX_EDGES       = 12;
  localparam int DRAIN_LIMIT     = 400;
  // Longest hold plus a glitch, times the pin steps of the longest pattern
  localparam int MAX_HOLD        = 7 * STABLE_CYCLES;
  localparam int MAX_PATTERN     = (2 * MAX_EDGES + 6) * MAX_HOLD;
  localparam int WATCHDOG_CYCLES = 16 + NUM_SCEN * 6 * MAX_PATTERN;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        scl_i;
  logic        sda_i;
  logic        enable_i;
  logic        hdr_mode_i;
  logic        event_ack_i;
  logic        event_req_o;
  event_code_t event_code_o;

  logic [31:0] lcg_state = 32'd95255;
  event_code_t expect_q[$];
  int          errors = 0;
  int          checks = 0;
  logic        glitch_on;
  logic        ack_hold;
  logic        ack_busy;
  int          ack_delay;

  always #CLK_HALF clk_i = ~clk_i;

  i3c_monitor_top UUT (
    .clk_i,
    .rst_ni,
    .scl_i,
    .sda_i,
    .enable_i,
    .hdr_mode_i,
    .event_ack_i,
    .event_req_o,
    .event_code_o
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return (lcg_next() >> 16) % n;
  endfunction

  // Expected report for one pattern, EV_NONE when the bus rules give nothing
  function automatic event_code_t expected_event(input bit is_hdr, input int unsigned edges,
                                                 input bit with_sr);
    if (!enable_i) begin
      return EV_NONE;
    end
    if (is_hdr) begin
      return (hdr_mode_i && edges == HDR_EXIT_EDGES) ? EV_HDR_EXIT : EV_NONE;
    end
    return (with_sr && edges >= TRST_EDGES) ? EV_TARGET_RESET : EV_NONE;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic hold_pins(input int unsigned cycles);
    int unsigned width;
    int unsigned pin;
    repeat (cycles / 2) @(negedge clk_i);
    // Short pulse on one pin while SCL is low, below the filter length
    if (glitch_on && !scl_i) begin
      width = 1 + rand_below(STABLE_CYCLES - 1);
      pin = rand_below(2);
      if (pin == 0) begin
        scl_i = ~scl_i;
      end else begin
        sda_i = ~sda_i;
      end
      repeat (width) @(negedge clk_i);
      if (pin == 0) begin
        scl_i = ~scl_i;
      end else begin
        sda_i = ~sda_i;
      end
    end
    repeat (cycles - cycles / 2) @(negedge clk_i);
  endtask

  task automatic set_pins(input logic scl, input logic sda);
    scl_i = scl;
    sda_i = sda;
    hold_pins(3 * STABLE_CYCLES + rand_below(3 * STABLE_CYCLES + 1));
  endtask

  // SCL low, SDA falls the given number of times, then P
  task automatic hdr_pattern(input int unsigned edges);
    set_pins(1'b0, 1'b1);
    for (int unsigned k = 0; k < edges; k++) begin
      set_pins(1'b0, 1'b0);
      if (k + 1 < edges) begin
        set_pins(1'b0, 1'b1);
      end
    end
    set_pins(1'b1, 1'b0);
    set_pins(1'b1, 1'b1);
  endtask

  // S, SDA falls with SCL low, optional Sr, then P
  task automatic trst_pattern(input int unsigned edges, input bit with_sr);
    set_pins(1'b1, 1'b0);
    set_pins(1'b0, 1'b0);
    for (int unsigned k = 0; k < edges; k++) begin
      set_pins(1'b0, 1'b1);
      set_pins(1'b0, 1'b0);
    end
    if (with_sr) begin
      set_pins(1'b0, 1'b1);
      set_pins(1'b1, 1'b1);
    end
    set_pins(1'b1, 1'b0);
    set_pins(1'b1, 1'b1);
  endtask

  task automatic drain_events();
    int waited;
    waited = 0;
    repeat (4 * SAMPLE_LATENCY) @(negedge clk_i);
    while ((expect_q.size() != 0 || ack_busy) && waited < DRAIN_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (expect_q.size() != 0) begin
      errors++;
      $display("ERROR: %0d expected event(s) never reported at %0t", expect_q.size(), $time);
      expect_q.delete();
    end
  endtask

  // One HDR exit is taken and held with ack high while more patterns complete
  task automatic run_burst();
    int unsigned extra;
    enable_i = 1'b1;
    hdr_mode_i = 1'b1;
    glitch_on = 1'b0;
    ack_delay = rand_below(8);
    ack_hold = 1'b1;
    expect_q.push_back(EV_HDR_EXIT);
    hdr_pattern(HDR_EXIT_EDGES);
    while (!(event_ack_i && !event_req_o)) @(negedge clk_i);
    trst_pattern(TRST_EDGES + rand_below(MAX_EDGES - TRST_EDGES + 1), 1'b1);
    hdr_pattern(HDR_EXIT_EDGES);
    extra = rand_below(3);
    for (int unsigned i = 0; i < extra; i++) begin
      if (rand_below(2) == 1) begin
        hdr_pattern(HDR_EXIT_EDGES);
      end else begin
        trst_pattern(TRST_EDGES + rand_below(MAX_EDGES - TRST_EDGES + 1), 1'b1);
      end
    end
    // Repeats merged into one flag per kind, HDR exit first
    expect_q.push_back(EV_HDR_EXIT);
    expect_q.push_back(EV_TARGET_RESET);
    ack_hold = 1'b0;
    drain_events();
  endtask

  task automatic run_scenario();
    int unsigned kind;
    int unsigned edges;
    event_code_t exp_code;
    kind = rand_below(5);
    if (kind == 4) begin
      run_burst();
    end else begin
      glitch_on = (rand_below(2) == 1);
      ack_delay = rand_below(8);
      enable_i = (rand_below(6) != 0);
      hdr_mode_i = (kind == 0) || (kind >= 2 && rand_below(2) == 1);
      if (kind == 0) begin
        edges = HDR_EXIT_EDGES - 1 + rand_below(3);
      end else if (kind == 1) begin
        edges = HDR_EXIT_EDGES;
      end else begin
        edges = TRST_EDGES - 1 + rand_below(MAX_EDGES - TRST_EDGES + 2);
      end
      exp_code = expected_event(kind <= 1, edges, kind == 2);
      if (exp_code != EV_NONE) begin
        expect_q.push_back(exp_code);
      end
      if (kind <= 1) begin
        hdr_pattern(edges);
      end else begin
        trst_pattern(edges, kind == 2);
      end
      drain_events();
    end
  endtask

  // Host side of the handshake, checks each code against the model queue
  initial begin
    event_code_t exp_code;
    event_ack_i = 1'b0;
    ack_busy = 1'b0;
    forever begin
      @(negedge clk_i);
      if (event_req_o) begin
        ack_busy = 1'b1;
        if (expect_q.size() == 0) begin
          errors++;
          $display("ERROR: event request with no event expected at %0t", $time);
        end else begin
          exp_code = expect_q.pop_front();
          check_value("event_code_o", 32'(event_code_o), 32'(exp_code));
        end
        repeat (ack_delay) @(negedge clk_i);
        event_ack_i = 1'b1;
        while (event_req_o) @(negedge clk_i);
        while (ack_hold) @(negedge clk_i);
        repeat (ack_delay) @(negedge clk_i);
        event_ack_i = 1'b0;
        @(negedge clk_i);
        ack_busy = 1'b0;
      end
    end
  end

  initial begin
    rst_ni = 1'b1;
    scl_i = 1'b1;
    sda_i = 1'b1;
    enable_i = 1'b1;
    hdr_mode_i = 1'b0;
    glitch_on = 1'b0;
    ack_hold = 1'b0;
    ack_delay = 0;
    #1 rst_ni = 1'b0;
    repeat (16) @(negedge clk_i);
    check_value("event_req_o", 32'(event_req_o), 32'd0);
    check_value("event_code_o", 32'(event_code_o), 32'(EV_NONE));
    rst_ni = 1'b1;
    repeat (4) @(negedge clk_i);
    for (int i = 0; i < NUM_SCEN; i++) begin
      run_scenario();
    end
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("ERROR: watchdog expired after %0d cycles, the run did not finish",
             WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
i3c_bus_pkg.sv
i3c_event_pkg.sv
i3c_bus_sampler.sv
target_reset_detector.sv
i3c_bus_monitor.sv
i3c_event_reporter.sv
i3c_monitor_top.sv
i3c_monitor_assert.sv
tb_i3c_monitor.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the I3C monitor testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_i3c_monitor \
  -Mdir obj_dir -o tb_i3c_monitor \
  -f vlog.f

./obj_dir/tb_i3c_monitor | tee sim.log

if grep -q "Regression passed" sim.log; then
  echo "Result: PASS"
else
  echo "Result: FAIL"
  exit 1
fi
